// File: verilog/isaPkg.sv
`default_nettype none

package isaPkg;

    typedef enum logic [3:0] {
        opOr     = 4'h0,
        opAnd    = 4'h1,
        opAdd    = 4'h2,
        opMul    = 4'h3,
        opRsv4   = 4'h4,
        opShl    = 4'h5,
        opLt     = 4'h6,
        opEq     = 4'h7,
        opGt     = 4'h8,
        opAndNot = 4'h9,
        opXor    = 4'hA,
        opSub    = 4'hB,
        opXnor   = 4'hC,
        opShr    = 4'hD,
        opNe     = 4'hE,
        opRsv15  = 4'hF
    } opcodeT;

    typedef struct packed {
        logic        spare;     // Overlaps the upper throw marker bit
        logic        kind;      // Swaps Y and the immediate
        logic        storing;
        logic        derefRhs;
        logic [3:0]  z;
        logic [3:0]  x;
        logic [3:0]  y;
        opcodeT      op;
        logic [11:0] imm;
    } opInsnT;

    typedef struct packed {
        logic [1:0]  marker;    // Both set for a throw
        logic [24:0] unused;
        logic [4:0]  vector;
    } throwInsnT;

    typedef union packed {
        opInsnT    opForm;
        throwInsnT throwForm;
    } insnT;

    localparam logic [3:0] zeroIndex = 4'd0;
    localparam logic [3:0] pcIndex   = 4'd15;   // Reads next PC, write means branch

endpackage

`default_nettype wire

// File: verilog/memMapPkg.sv
`default_nettype none

package memMapPkg;

    // Word addresses
    localparam logic [31:0] resetVector  = 32'h0000_0040;
    localparam logic [31:0] vectorBase   = 32'h0000_0020;   // 32 entries
    localparam logic [31:0] trampAddr    = 32'h0000_0008;
    localparam logic [31:0] trapSaveAddr = 32'h0000_0001;

    // Core data side request, answered in the same cycle
    typedef struct packed {
        logic        strobe;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wData;
    } dataReqT;

    // Host side request, honored only while halted
    typedef struct packed {
        logic        en;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wData;
    } hostReqT;

endpackage

`default_nettype wire

// File: verilog/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import isaPkg::*; (
    input  logic        clk,
    input  logic        writeEn,
    input  logic [3:0]  indexZ,
    input  logic [3:0]  indexX,
    input  logic [3:0]  indexY,
    input  logic [31:0] writeZ,
    input  logic [31:0] nextPc,
    output logic [31:0] valueZ,
    output logic [31:0] valueX,
    output logic [31:0] valueY
);

    logic [31:0] regs [1:14];   // Only the real registers are stored

    function automatic logic [31:0] readReg(input logic [3:0]  index,
                                            input logic [31:0] stored,
                                            input logic [31:0] pc);
        if (index == zeroIndex)
            return '0;
        else if (index == pcIndex)
            return pc;
        else
            return stored;
    endfunction

    assign valueZ = readReg(indexZ, regs[indexZ], nextPc);
    assign valueX = readReg(indexX, regs[indexX], nextPc);
    assign valueY = readReg(indexY, regs[indexY], nextPc);

    always_ff @(posedge clk) begin
        if (writeEn && indexZ != zeroIndex && indexZ != pcIndex) begin
            regs[indexZ] <= writeZ;
        end
    end

endmodule

`default_nettype wire

// File: verilog/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit import isaPkg::*; (
    input  logic        clk,
    input  logic        en,
    input  logic        swap,
    input  opcodeT      op,
    input  logic [31:0] x,
    input  logic [31:0] y,
    input  logic [31:0] imm,
    output logic [31:0] result
);

    logic [31:0] operand;
    logic [31:0] addend;
    logic [31:0] opValue;
    logic        reserved;

    assign operand = swap ? imm : y;
    assign addend  = swap ? y : imm;

    always_comb begin
        opValue  = '0;
        reserved = 1'b0;
        unique case (op)
            opOr:     opValue = x | operand;
            opAnd:    opValue = x & operand;
            opAdd:    opValue = x + operand;
            opMul:    opValue = x * operand;   // Low word only
            opShl:    opValue = x << operand;
            opLt:     opValue = {32{$signed(x) < $signed(operand)}};
            opEq:     opValue = {32{x == operand}};
            opGt:     opValue = {32{$signed(x) > $signed(operand)}};
            opAndNot: opValue = x & ~operand;
            opXor:    opValue = x ^ operand;
            opSub:    opValue = x - operand;
            opXnor:   opValue = x ~^ operand;
            opShr:    opValue = x >> operand;   // Logical
            opNe:     opValue = {32{x != operand}};
            opRsv4, opRsv15: begin
                reserved = 1'b1;   // No addend either
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (en) begin
            result <= reserved ? '0 : opValue + addend;
        end
    end

endmodule

`default_nettype wire

// File: verilog/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore import isaPkg::*, memMapPkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        halt,
    input  logic        trap,
    output logic [31:0] iAddr,
    input  insnT        iData,
    output dataReqT     dataReq,
    input  logic [31:0] dIn
);

    typedef enum logic [3:0] {
        sIdle, s0, s1, s2, s3, s4, s5,
        sThrow, sTrap, sVecRead, sSaveRet, sSaveWr
    } stateT;

    stateT       state;
    stateT       nextState;
    opInsnT      opF;
    logic        isThrow;
    logic        loading;
    logic        branch;
    logic        regWrite;
    logic        execEn;
    logic [31:0] extImm;
    logic [31:0] execResult;
    logic [31:0] valueZ, valueX, valueY;
    logic [31:0] rhs;
    logic [31:0] rResult;   // Latched ALU result or return address
    logic [31:0] rData;
    logic [31:0] nextPc;
    logic [31:0] vAddr;     // Handler address for throw and trap

    // Decode through the union
    assign opF     = iData.opForm;
    assign isThrow = &iData.throwForm.marker;
    assign extImm  = {{20{opF.imm[11]}}, opF.imm};
    assign loading = opF.derefRhs && !opF.storing;
    assign branch  = opF.z == pcIndex && !opF.storing;
    assign rhs     = loading ? rData : rResult;

    always_comb begin
        nextState = state;
        case (state)
            sIdle:    nextState = halt ? sIdle : s5;
            s0: begin
                if (halt)
                    nextState = sIdle;
                else if (trap)
                    nextState = sTrap;
                else if (isThrow)
                    nextState = sThrow;
                else
                    nextState = s1;
            end
            s1:       nextState = s2;
            s2:       nextState = s3;   // Settling for the multiplier
            s3:       nextState = s4;
            s4:       nextState = s5;
            s5:       nextState = s0;
            sThrow:   nextState = sVecRead;
            sTrap:    nextState = sSaveRet;
            sVecRead: nextState = sSaveRet;
            sSaveRet: nextState = sSaveWr;
            sSaveWr:  nextState = s5;
            default:  nextState = sIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n)
            state <= sIdle;
        else
            state <= nextState;
    end

    always_ff @(posedge clk) begin
        case (state)
            sIdle:    iAddr   <= resetVector;
            s1:       rResult <= execResult;
            s3:       rData   <= dIn;
            s4:       iAddr   <= branch ? rhs : nextPc;
            s5:       nextPc  <= iAddr + 32'd1;
            sThrow:   rResult <= nextPc;   // Resume after the throw
            sVecRead: vAddr   <= dIn;
            sTrap: begin
                rResult <= iAddr;   // Rerun the preempted instruction
                vAddr   <= trampAddr;
            end
            sSaveWr:  iAddr   <= vAddr;
            default: ;
        endcase
    end

    always_comb begin
        dataReq = '0;
        case (state)
            s3: begin
                dataReq.strobe = loading || opF.storing;
                dataReq.write  = opF.storing;
                dataReq.addr   = (opF.storing && opF.derefRhs) ? valueZ : rResult;
                dataReq.wData  = (opF.storing && opF.derefRhs) ? rResult : valueZ;
            end
            sVecRead: begin
                dataReq.strobe = 1'b1;
                dataReq.addr   = vectorBase + 32'(iData.throwForm.vector);
            end
            sSaveWr: begin
                dataReq.strobe = 1'b1;
                dataReq.write  = 1'b1;
                dataReq.addr   = trapSaveAddr;
                dataReq.wData  = rResult;
            end
            default: ;
        endcase
    end

    assign execEn   = state == s0;
    assign regWrite = state == s4 && !opF.storing;

    execUnit execUnit_i (
        .clk    (clk),
        .en     (execEn),
        .swap   (opF.kind),
        .op     (opF.op),
        .x      (valueX),
        .y      (valueY),
        .imm    (extImm),
        .result (execResult)
    );

    regFile regFile_i (
        .clk     (clk),
        .writeEn (regWrite),
        .indexZ  (opF.z),
        .indexX  (opF.x),
        .indexY  (opF.y),
        .writeZ  (rhs),
        .nextPc  (nextPc),
        .valueZ  (valueZ),
        .valueX  (valueX),
        .valueY  (valueY)
    );

endmodule

`default_nettype wire

// File: verilog/sysMemory.sv
`timescale 1ns/1ps
`default_nettype none

module sysMemory import isaPkg::*, memMapPkg::*; #(
    parameter int memWords = 1024
) (
    input  logic        clk,
    input  logic        halt,
    input  logic [31:0] iAddr,
    output insnT        iData,
    input  dataReqT     dataReq,
    output logic [31:0] dIn,
    input  hostReqT     hostReq,
    output logic [31:0] hostRData
);

    localparam int addrBits = $clog2(memWords);

    logic [31:0]         mem [memWords];
    logic [addrBits-1:0] iIndex;
    logic [addrBits-1:0] dIndex;
    logic [addrBits-1:0] hIndex;
    logic                hostAccess;

    // Addresses wrap modulo the memory size
    assign iIndex = iAddr[addrBits-1:0];
    assign dIndex = dataReq.addr[addrBits-1:0];
    assign hIndex = hostReq.addr[addrBits-1:0];

    assign hostAccess = halt && hostReq.en;   // Host locked out while running

    assign iData = insnT'(mem[iIndex]);
    assign dIn   = mem[dIndex];   // Same cycle answer, no wait states

    always_ff @(posedge clk) begin
        if (dataReq.strobe && dataReq.write) begin
            mem[dIndex] <= dataReq.wData;
        end
        if (hostAccess && hostReq.write) begin
            mem[hIndex] <= hostReq.wData;
        end
    end

    always_ff @(posedge clk) begin
        if (hostAccess && !hostReq.write) begin
            hostRData <= mem[hIndex];   // One clock read latency
        end
    end

endmodule

`default_nettype wire

// File: verilog/cpuSystem.sv
`timescale 1ns/1ps
`default_nettype none

module cpuSystem import isaPkg::*, memMapPkg::*; #(
    parameter int memWords = 1024
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        halt,
    input  logic        trap,
    input  hostReqT     hostReq,
    output logic [31:0] hostRData
);

    logic [31:0] iAddr;
    insnT        iData;
    dataReqT     dataReq;
    logic [31:0] dIn;

    cpuCore cpuCore_i (
        .clk     (clk),
        .reset_n (reset_n),
        .halt    (halt),
        .trap    (trap),
        .iAddr   (iAddr),
        .iData   (iData),
        .dataReq (dataReq),
        .dIn     (dIn)
    );

    sysMemory #(
        .memWords (memWords)
    ) sysMemory_i (
        .clk       (clk),
        .halt      (halt),
        .iAddr     (iAddr),
        .iData     (iData),
        .dataReq   (dataReq),
        .dIn       (dIn),
        .hostReq   (hostReq),
        .hostRData (hostRData)
    );

endmodule

`default_nettype wire

// File: tb/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int period      = 40,
    parameter int resetCycles = 3
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #2 reset_n = 1'b1;   // Released just after the edge
    end

endmodule

`default_nettype wire

// File: tb/cpuSystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuSystemTb import memMapPkg::*; ();

    localparam int memWords     = 1024;
    localparam int clkPeriod    = 40;
    localparam int driveDelay   = 2;
    localparam int settleCycles = 20;   // Margin after the run length
    localparam int haltCycles   = 8;    // Core drains to idle before host access

    logic        clk;
    logic        reset_n;
    logic        halt;
    logic        trap;
    hostReqT     hostReq;
    logic [31:0] hostRData;

    logic [31:0] stim [0:1023];
    int          pos;
    int          curErrors;
    int          passCount;
    int          failCount;
    int          testNum;
    longint      wdLimit = 0;

    clockGen #(.period(clkPeriod), .resetCycles(3)) clockGen_i (
        .clk     (clk),
        .reset_n (reset_n)
    );

    cpuSystem #(.memWords(memWords)) cpuSystem_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .halt      (halt),
        .trap      (trap),
        .hostReq   (hostReq),
        .hostRData (hostRData)
    );

    task automatic hostWrite(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        #driveDelay;
        hostReq.en    = 1'b1;
        hostReq.write = 1'b1;
        hostReq.addr  = addr;
        hostReq.wData = data;
        @(posedge clk);   // Write lands here
        #driveDelay;
        hostReq = '0;
    endtask

    task automatic hostRead(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        #driveDelay;
        hostReq.en    = 1'b1;
        hostReq.write = 1'b0;
        hostReq.addr  = addr;
        hostReq.wData = 32'h0;
        @(posedge clk);   // Read data registered at this edge
        #driveDelay;
        data    = hostRData;
        hostReq = '0;
    endtask

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
            curErrors++;
        end
    endtask

    // Cycles the whole stimulus file needs, loads and readback included
    function automatic longint stimulusCycles();
        int     p;
        longint cycles;
        int     nSeg;
        p      = 0;
        cycles = 0;
        while (p < 1000 && stim[p] !== 32'h0) begin
            nSeg = stim[p];
            p++;
            for (int s = 0; s < nSeg; s++) begin
                cycles += 2 * stim[p + 1];
                p += 2 + stim[p + 1];
            end
            cycles += stim[p + 1] * 6 + settleCycles + haltCycles + 2 * stim[p + 2] + 4;
            p += 3 + 2 * stim[p + 2];
        end
        return cycles;
    endfunction

    task automatic runTest(input int num);
        int          nSeg;
        int          len;
        logic [31:0] base;
        logic [31:0] trapCycle;
        int          runLen;
        int          nPairs;
        logic [31:0] addr;
        logic [31:0] got;
        curErrors = 0;
        nSeg = stim[pos];
        pos++;
        for (int s = 0; s < nSeg; s++) begin
            base = stim[pos];
            len  = stim[pos + 1];
            pos += 2;
            for (int i = 0; i < len; i++) begin
                hostWrite(base + i, stim[pos]);
                pos++;
            end
        end
        trapCycle = stim[pos];
        runLen    = stim[pos + 1];
        nPairs    = stim[pos + 2];
        pos += 3;
        @(posedge clk);
        #driveDelay;
        halt = 1'b0;
        for (int c = 1; c <= runLen * 6 + settleCycles; c++) begin
            @(posedge clk);
            #driveDelay;
            trap = (32'(c) == trapCycle);   // One cycle wide, lined up with s0
        end
        halt = 1'b1;
        repeat (haltCycles) @(posedge clk);
        for (int i = 0; i < nPairs; i++) begin
            addr = stim[pos];
            hostRead(addr, got);
            compareValue($sformatf("mem[%h]", addr), got, stim[pos + 1]);
            pos += 2;
        end
        if (curErrors == 0) begin
            passCount++;
            $display("test %0d passed", num);
        end else begin
            failCount++;
            $display("test %0d failed with %0d wrong words", num, curErrors);
        end
    endtask

    initial begin
        halt      = 1'b1;
        trap      = 1'b0;
        hostReq   = '0;
        pos       = 0;
        passCount = 0;
        failCount = 0;
        testNum   = 0;
        $readmemh("tb/cpuStimulus.dat", stim);
        wdLimit = 2 * stimulusCycles() * clkPeriod + 20 * clkPeriod;
        wait (reset_n === 1'b1);
        while (pos < 1000 && stim[pos] !== 32'h0) begin
            testNum++;
            runTest(testNum);
        end
        $display("%0d tests passed, %0d failed", passCount, failCount);
        if (failCount == 0 && passCount > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (wdLimit > 0);
        #(wdLimit);
        $display("run timed out before all tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: cpuSystem.f
verilog/isaPkg.sv
verilog/memMapPkg.sv
verilog/regFile.sv
verilog/execUnit.sv
verilog/cpuCore.sv
verilog/sysMemory.sv
verilog/cpuSystem.sv
tb/clockGen.sv
tb/cpuSystemTb.sv

// File: tb/cpuStimulus.dat
// Per test: segment count, each segment as base, length, words, then trap cycle
// (FFFFFFFF for none), run length in instructions, pair count, address/value pairs
00000001 00000040 0000003C
01000FFA 02000003 03000200
33120010 03302001 73120005 03302001 33121010 03302001 73121005 03302001
33122010 03302001 73122005 03302001 33123010 03302001 73123005 03302001
33125010 03302001 73125005 03302001 33126010 03302001 73126005 03302001
33127010 03302001 73127005 03302001 33128010 03302001 73128005 03302001
33129010 03302001 73129005 03302001 3312A010 03302001 7312A005 03302001
3312B010 03302001 7312B005 03302001 3312C010 03302001 7312C005 03302001
3312D010 03302001 7312D005 03302001 3312E010 03302001 7312E005 03302001
0F00007B FFFFFFFF 00000040 0000001C
00000200 0000000B 00000201 00000002 00000202 00000012 00000203 00000003
00000204 0000000D 00000205 00000002 00000206 FFFFFFFE 00000207 FFFFFFE5
00000208 FFFFFFE0 00000209 FFFFFF43 0000020A 0000000F 0000020B 00000002
0000020C 00000010 0000020D 00000003 0000020E 00000010 0000020F 00000003
00000210 00000008 00000211 FFFFFFFD 00000212 00000009 00000213 00000002
00000214 00000007 00000215 FFFFFFF8 00000216 00000016 00000217 00000003
00000218 2000000F 00000219 08000002 0000021A 0000000F 0000021B 00000002
00000001 00000040 00000008 04000300 340005A5 15400000 16000047 25000301 26000302
0F000046 CAFEF00D FFFFFFFF 0000000A 00000003
00000300 000005A5 00000301 000005A5 00000302 CAFEF00D
00000001 00000040 00000005 07000077 27000310 00000123 20000310 0F000044
FFFFFFFF 00000008 00000001 00000310 00000000
00000001 00000040 00000006 08000011 20000321 0FF02001 28000321 28000322 0F000045
FFFFFFFF 0000000A 00000002 00000321 00000000 00000322 00000011
00000001 00000040 0000000A 09000048 29000023 0A000055 C0000003 2A000331
0F000045 00000000 00000000 2A000330 1F000001 FFFFFFFF 0000000C 00000003
00000001 00000044 00000330 00000055 00000331 00000055
00000002 00000008 00000002 2B000340 1F000001 00000040 00000004
0B000066 0C000077 2C000341 0F000043 00000008 0000000C 00000003
00000001 00000041 00000340 00000066 00000341 00000077
00000000
